// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;

    // Data word, address or instruction
    typedef logic [wordWidth-1:0] word_t;

    typedef logic [regAddrWidth-1:0] regAddr_t;

    // First fetch address
    localparam word_t resetVector = '0;

    localparam int regCount = 32;

endpackage

`default_nettype wire

// ==== rtl/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Major opcodes
    localparam opcode_t opSpecial = 6'h00;
    localparam opcode_t opJ = 6'h02;
    localparam opcode_t opBeq = 6'h04;
    localparam opcode_t opBne = 6'h05;
    localparam opcode_t opAddiu = 6'h09;
    localparam opcode_t opOri = 6'h0d;
    localparam opcode_t opLui = 6'h0f;
    localparam opcode_t opLw = 6'h23;
    localparam opcode_t opSw = 6'h2b;

    // Function field of SPECIAL
    localparam funct_t fnAddu = 6'h21;
    localparam funct_t fnSubu = 6'h23;
    localparam funct_t fnAnd = 6'h24;
    localparam funct_t fnOr = 6'h25;
    localparam funct_t fnSlt = 6'h2a;

    typedef enum logic [2:0] {
        addOp,
        subOp,
        andOp,
        orOp,
        sltOp,
        luiOp
    } aluOp_t;

    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbMem
    } wbSource_t;

endpackage

`default_nettype wire

// ==== rtl/stageLink.sv ====
`timescale 1ns/1ns
`default_nettype none

interface forwardBus;
    import cpuPkg::*;

    logic fwdValid;
    logic fwdReady;
    regAddr_t fwdAddr;
    word_t fwdValue;

    modport source (output fwdValid, output fwdReady, output fwdAddr, output fwdValue);
    modport sink (input fwdValid, input fwdReady, input fwdAddr, input fwdValue);
endinterface

interface execBus;
    import cpuPkg::*;
    import isaPkg::*;

    logic issue;
    word_t pc;
    aluOp_t aluOp;
    word_t operandA;
    word_t operandB;
    word_t storeData;
    regAddr_t destReg;
    wbSource_t wbSource;
    logic memLoad;
    logic memStore;
    // Back-pressure from execute
    logic memWait;

    modport sender (
        output issue, output pc, output aluOp, output operandA, output operandB,
        output storeData, output destReg, output wbSource, output memLoad, output memStore,
        input memWait
    );
    modport receiver (
        input issue, input pc, input aluOp, input operandA, input operandB,
        input storeData, input destReg, input wbSource, input memLoad, input memStore,
        output memWait
    );
endinterface

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input logic clk,
    input logic reset,
    input logic hold,
    input logic jump,
    input cpuPkg::word_t jumpTarget,
    output cpuPkg::word_t instAddr,
    output logic instRead,
    input cpuPkg::word_t instData,
    input logic instValid,
    output cpuPkg::word_t fetchedInstr,
    output cpuPkg::word_t fetchedPc,
    output logic fetchedValid
);
    import cpuPkg::*;

    word_t pc;
    word_t nextPc;
    word_t pendingTarget;
    logic readEnable;
    logic pendingJump;
    logic accept;

    assign accept = readEnable && instValid && !hold;

    // Redirect waits for the delay slot to be taken
    always_comb begin
        nextPc = pc + 32'd4;
        if (jump) begin
            nextPc = jumpTarget;
        end else if (pendingJump) begin
            nextPc = pendingTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            readEnable <= 1'b0;
            pendingJump <= 1'b0;
        end else begin
            readEnable <= 1'b1;
            if (!hold) begin
                if (accept) begin
                    pc <= nextPc;
                    pendingJump <= 1'b0;
                end else if (jump) begin
                    pendingJump <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && jump) begin
            pendingTarget <= jumpTarget;
        end
    end

    assign instAddr = pc;
    assign instRead = readEnable;
    assign fetchedInstr = instData;
    assign fetchedPc = pc;
    assign fetchedValid = accept;

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input logic clk,
    input logic reset,
    input cpuPkg::regAddr_t readAddrA,
    input cpuPkg::regAddr_t readAddrB,
    output cpuPkg::word_t readDataA,
    output cpuPkg::word_t readDataB,
    input cpuPkg::regAddr_t writeAddr,
    input cpuPkg::word_t writeData
);
    import cpuPkg::*;

    word_t regs [regCount];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Register zero reads as zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input logic clk,
    input logic reset,
    input cpuPkg::word_t fetchedInstr,
    input cpuPkg::word_t fetchedPc,
    input logic fetchedValid,
    input cpuPkg::regAddr_t writeAddr,
    input cpuPkg::word_t writeData,
    forwardBus.sink fwdExec,
    forwardBus.sink fwdWb,
    execBus.sender exec,
    output logic hold,
    output logic jump,
    output cpuPkg::word_t jumpTarget
);
    import cpuPkg::*;
    import isaPkg::*;

    word_t dInstr;
    word_t dPc;
    logic dValid;

    opcode_t opcode;
    funct_t funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    word_t immExt;
    word_t fileA;
    word_t fileB;
    word_t valueA;
    word_t valueB;
    word_t slotPc;
    word_t branchTarget;
    logic execHitA;
    logic execHitB;
    logic wbHitA;
    logic wbHitB;
    logic pendingA;
    logic pendingB;
    logic rType;
    logic useRs;
    logic useRt;
    logic immOperand;
    logic immZero;
    logic isBranch;
    logic branchNe;
    logic isJump;
    logic taken;
    logic stall;
    aluOp_t aluOp;
    wbSource_t wbSource;
    regAddr_t destReg;
    logic memLoad;
    logic memStore;

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!hold) begin
            dValid <= fetchedValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            dInstr <= fetchedInstr;
            dPc <= fetchedPc;
        end
    end

    assign opcode = dInstr[31:26];
    assign rs = dInstr[25:21];
    assign rt = dInstr[20:16];
    assign rd = dInstr[15:11];
    assign funct = dInstr[5:0];
    assign immExt = immZero ? {16'b0, dInstr[15:0]} : {{16{dInstr[15]}}, dInstr[15:0]};

    always_comb begin
        rType = 1'b0;
        useRs = 1'b0;
        useRt = 1'b0;
        immOperand = 1'b1;
        immZero = 1'b0;
        isBranch = 1'b0;
        branchNe = 1'b0;
        isJump = 1'b0;
        aluOp = addOp;
        wbSource = wbNone;
        destReg = '0;
        memLoad = 1'b0;
        memStore = 1'b0;
        case (opcode)
            opSpecial: begin
                rType = 1'b1;
                case (funct)
                    fnAddu: aluOp = addOp;
                    fnSubu: aluOp = subOp;
                    fnAnd: aluOp = andOp;
                    fnOr: aluOp = orOp;
                    fnSlt: aluOp = sltOp;
                    default: rType = 1'b0;
                endcase
                useRs = rType;
                useRt = rType;
                immOperand = 1'b0;
                destReg = rType ? rd : '0;
                wbSource = rType ? wbAlu : wbNone;
            end
            opAddiu, opOri, opLui: begin
                useRs = (opcode != opLui);
                immZero = (opcode != opAddiu);
                aluOp = (opcode == opOri) ? orOp : (opcode == opLui) ? luiOp : addOp;
                destReg = rt;
                wbSource = wbAlu;
            end
            opLw: begin
                useRs = 1'b1;
                destReg = rt;
                wbSource = wbMem;
                memLoad = 1'b1;
            end
            opSw: begin
                useRs = 1'b1;
                useRt = 1'b1;
                memStore = 1'b1;
            end
            opBeq, opBne: begin
                useRs = 1'b1;
                useRt = 1'b1;
                isBranch = 1'b1;
                branchNe = (opcode == opBne);
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    registerFile i_registerFile (
        .clk(clk),
        .reset(reset),
        .readAddrA(rs),
        .readAddrB(rt),
        .readDataA(fileA),
        .readDataB(fileB),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    assign execHitA = fwdExec.fwdValid && fwdExec.fwdAddr == rs;
    assign execHitB = fwdExec.fwdValid && fwdExec.fwdAddr == rt;
    assign wbHitA = fwdWb.fwdValid && fwdWb.fwdAddr == rs;
    assign wbHitB = fwdWb.fwdValid && fwdWb.fwdAddr == rt;

    // Execute wins over writeback
    assign valueA = execHitA ? fwdExec.fwdValue : wbHitA ? fwdWb.fwdValue : fileA;
    assign valueB = execHitB ? fwdExec.fwdValue : wbHitB ? fwdWb.fwdValue : fileB;
    assign pendingA = execHitA ? !fwdExec.fwdReady : (wbHitA && !fwdWb.fwdReady);
    assign pendingB = execHitB ? !fwdExec.fwdReady : (wbHitB && !fwdWb.fwdReady);

    assign stall = dValid && ((useRs && pendingA) || (useRt && pendingB));
    assign hold = stall || exec.memWait;

    assign taken = branchNe ? (valueA != valueB) : (valueA == valueB);
    assign slotPc = dPc + 32'd4;
    assign branchTarget = slotPc + {immExt[29:0], 2'b00};
    assign jump = dValid && !stall && (isBranch || isJump);

    always_comb begin
        if (isJump) begin
            jumpTarget = {slotPc[31:28], dInstr[25:0], 2'b00};
        end else if (taken) begin
            jumpTarget = branchTarget;
        end else begin
            // Not taken continues after the delay slot
            jumpTarget = slotPc + 32'd4;
        end
    end

    assign exec.issue = dValid && !stall;
    assign exec.pc = dPc;
    assign exec.aluOp = aluOp;
    assign exec.operandA = valueA;
    assign exec.operandB = immOperand ? immExt : valueB;
    assign exec.storeData = valueB;
    assign exec.destReg = destReg;
    assign exec.wbSource = wbSource;
    assign exec.memLoad = memLoad;
    assign exec.memStore = memStore;

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input logic clk,
    input logic reset,
    execBus.receiver exec,
    forwardBus.source fwdExec,
    output cpuPkg::word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output cpuPkg::word_t dataWdata,
    input cpuPkg::word_t dataRdata,
    input logic dataValid,
    output cpuPkg::word_t result,
    output cpuPkg::regAddr_t resultDest,
    output logic resultWrite,
    output cpuPkg::word_t resultPc,
    output logic resultValid
);
    import cpuPkg::*;
    import isaPkg::*;

    logic eValid;
    word_t ePc;
    aluOp_t eAluOp;
    word_t eA;
    word_t eB;
    word_t eStoreData;
    regAddr_t eDest;
    wbSource_t eWbSource;
    logic eLoad;
    logic eStore;
    word_t aluResult;
    logic memWait;

    always_ff @(posedge clk) begin
        if (reset) begin
            eValid <= 1'b0;
        end else if (!memWait) begin
            eValid <= exec.issue;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            ePc <= exec.pc;
            eAluOp <= exec.aluOp;
            eA <= exec.operandA;
            eB <= exec.operandB;
            eStoreData <= exec.storeData;
            eDest <= exec.destReg;
            eWbSource <= exec.wbSource;
            eLoad <= exec.memLoad;
            eStore <= exec.memStore;
        end
    end

    // Also forms the load/store address
    always_comb begin
        case (eAluOp)
            subOp: aluResult = eA - eB;
            andOp: aluResult = eA & eB;
            orOp: aluResult = eA | eB;
            sltOp: aluResult = ($signed(eA) < $signed(eB)) ? 32'd1 : 32'd0;
            luiOp: aluResult = {eB[15:0], 16'b0};
            default: aluResult = eA + eB;
        endcase
    end

    assign dataAddr = aluResult;
    assign dataRead = eValid && eLoad;
    assign dataWrite = eValid && eStore;
    assign dataWdata = eStoreData;
    assign memWait = (dataRead || dataWrite) && !dataValid;
    assign exec.memWait = memWait;

    // Loads are not ready until writeback
    assign fwdExec.fwdValid = eValid && eDest != '0;
    assign fwdExec.fwdReady = (eWbSource == wbAlu);
    assign fwdExec.fwdAddr = eDest;
    assign fwdExec.fwdValue = aluResult;

    assign result = (eWbSource == wbMem) ? dataRdata : aluResult;
    assign resultDest = eDest;
    assign resultWrite = eValid && !memWait && eWbSource != wbNone;
    assign resultPc = ePc;
    assign resultValid = eValid && !memWait;

endmodule

`default_nettype wire

// ==== rtl/writebackStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writebackStage (
    input logic clk,
    input logic reset,
    input cpuPkg::word_t result,
    input cpuPkg::regAddr_t resultDest,
    input logic resultWrite,
    input cpuPkg::word_t resultPc,
    input logic resultValid,
    forwardBus.source fwdWb,
    output cpuPkg::regAddr_t writeAddr,
    output cpuPkg::word_t writeData,
    output cpuPkg::word_t debugPc,
    output logic [3:0] debugWen,
    output cpuPkg::regAddr_t debugWnum,
    output cpuPkg::word_t debugWdata
);
    import cpuPkg::*;

    logic wValid;
    logic wWrite;
    regAddr_t wDest;
    word_t wResult;
    word_t wPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            wValid <= 1'b0;
            wWrite <= 1'b0;
        end else begin
            wValid <= resultValid;
            wWrite <= resultWrite;
        end
    end

    always_ff @(posedge clk) begin
        wDest <= resultDest;
        wResult <= result;
        wPc <= resultPc;
    end

    // Address zero means no write
    assign writeAddr = wWrite ? wDest : '0;
    assign writeData = wResult;

    assign fwdWb.fwdValid = writeAddr != '0;
    assign fwdWb.fwdReady = 1'b1;
    assign fwdWb.fwdAddr = writeAddr;
    assign fwdWb.fwdValue = wResult;

    assign debugPc = wValid ? wPc : '0;
    assign debugWen = (writeAddr != '0) ? 4'b1111 : 4'b0000;
    assign debugWnum = writeAddr;
    assign debugWdata = wResult;

endmodule

`default_nettype wire

// ==== rtl/mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
    input logic clk,
    input logic reset,
    output cpuPkg::word_t instAddr,
    output logic instRead,
    input cpuPkg::word_t instData,
    input logic instValid,
    output cpuPkg::word_t dataAddr,
    output logic dataRead,
    output logic dataWrite,
    output cpuPkg::word_t dataWdata,
    input cpuPkg::word_t dataRdata,
    input logic dataValid,
    output cpuPkg::word_t debugPc,
    output logic [3:0] debugWen,
    output cpuPkg::regAddr_t debugWnum,
    output cpuPkg::word_t debugWdata
);
    import cpuPkg::*;

    word_t fetchedInstr;
    word_t fetchedPc;
    logic fetchedValid;
    logic hold;
    logic jump;
    word_t jumpTarget;
    regAddr_t writeAddr;
    word_t writeData;
    word_t result;
    regAddr_t resultDest;
    logic resultWrite;
    word_t resultPc;
    logic resultValid;

    forwardBus fwdExecLink ();
    forwardBus fwdWbLink ();
    execBus execLink ();

    fetchUnit i_fetchUnit (
        .clk(clk),
        .reset(reset),
        .hold(hold),
        .jump(jump),
        .jumpTarget(jumpTarget),
        .instAddr(instAddr),
        .instRead(instRead),
        .instData(instData),
        .instValid(instValid),
        .fetchedInstr(fetchedInstr),
        .fetchedPc(fetchedPc),
        .fetchedValid(fetchedValid)
    );

    decodeStage i_decodeStage (
        .clk(clk),
        .reset(reset),
        .fetchedInstr(fetchedInstr),
        .fetchedPc(fetchedPc),
        .fetchedValid(fetchedValid),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .fwdExec(fwdExecLink),
        .fwdWb(fwdWbLink),
        .exec(execLink),
        .hold(hold),
        .jump(jump),
        .jumpTarget(jumpTarget)
    );

    executeStage i_executeStage (
        .clk(clk),
        .reset(reset),
        .exec(execLink),
        .fwdExec(fwdExecLink),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .result(result),
        .resultDest(resultDest),
        .resultWrite(resultWrite),
        .resultPc(resultPc),
        .resultValid(resultValid)
    );

    writebackStage i_writebackStage (
        .clk(clk),
        .reset(reset),
        .result(result),
        .resultDest(resultDest),
        .resultWrite(resultWrite),
        .resultPc(resultPc),
        .resultValid(resultValid),
        .fwdWb(fwdWbLink),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .debugPc(debugPc),
        .debugWen(debugWen),
        .debugWnum(debugWnum),
        .debugWdata(debugWdata)
    );

endmodule

`default_nettype wire

// ==== test/isaModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module isaModel;
    import cpuPkg::*;
    import isaPkg::*;

    localparam int programLength = 200;
    localparam int memWords = 16;
    localparam int maxWrites = 1024;
    localparam int maxSteps = 4000;

    word_t programWords [256];
    word_t startMem [memWords];
    word_t finalMem [memWords];
    word_t expPc [maxWrites];
    regAddr_t expReg [maxWrites];
    word_t expValue [maxWrites];
    int writeCount;
    int kind [programLength];

    // Initial data word from the whole byte address
    function automatic word_t fillWord(int unsigned index);
        word_t a;
        a = word_t'(index) * 32'd4;
        return (a * 32'h9e3779b9) ^ {a[15:0], ~a[15:0]};
    endfunction

    // Kinds 17..19 are BEQ, BNE and J
    task automatic buildProgram();
        int target;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        funct_t fn;
        logic [15:0] imm;
        logic [15:0] offset;
        for (int i = 0; i < 256; i++) begin
            programWords[i] = '0;
        end
        for (int i = 0; i < programLength; i++) begin
            kind[i] = $urandom % 20;
            // No control instruction in a delay slot or at the end
            if (i == programLength - 1 || (i > 0 && kind[i-1] >= 17)) begin
                kind[i] = $urandom % 17;
            end
        end
        for (int i = 0; i < programLength; i++) begin
            rs = regAddr_t'($urandom % 8);
            rt = regAddr_t'($urandom % 8);
            rd = regAddr_t'($urandom % 8);
            imm = 16'($urandom);
            offset = 16'(4 * ($urandom % memWords));
            target = i + 2 + $urandom % 8;
            if (target > programLength) begin
                target = programLength;
            end
            // Never land on a delay slot
            if (kind[target-1] >= 17) begin
                target = i + 2;
            end
            case ($urandom % 5)
                0: fn = fnAddu;
                1: fn = fnSubu;
                2: fn = fnAnd;
                3: fn = fnOr;
                default: fn = fnSlt;
            endcase
            if (kind[i] <= 5) begin
                programWords[i] = {opSpecial, rs, rt, rd, 5'b0, fn};
            end else if (kind[i] <= 7) begin
                programWords[i] = {opAddiu, rs, rt, imm};
            end else if (kind[i] <= 9) begin
                programWords[i] = {opOri, rs, rt, imm};
            end else if (kind[i] == 10) begin
                programWords[i] = {opLui, 5'b0, rt, imm};
            end else if (kind[i] <= 13) begin
                programWords[i] = {opLw, 5'b0, rt, offset};
            end else if (kind[i] <= 16) begin
                programWords[i] = {opSw, 5'b0, rt, offset};
            end else if (kind[i] == 17) begin
                programWords[i] = {opBeq, rs, rt, 16'(target - i - 1)};
            end else if (kind[i] == 18) begin
                programWords[i] = {opBne, rs, rt, 16'(target - i - 1)};
            end else begin
                programWords[i] = {opJ, 26'(target)};
            end
        end
        // J to itself and a no-op close the program
        programWords[programLength] = {opJ, 26'(programLength)};
        programWords[programLength+1] = '0;
    endtask

    task automatic runProgram();
        word_t regs [regCount];
        word_t mem [memWords];
        word_t instr;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        word_t value;
        regAddr_t dest;
        opcode_t op;
        int pc;
        int npc;
        int nextNpc;
        int steps;
        for (int r = 0; r < regCount; r++) begin
            regs[r] = '0;
        end
        for (int k = 0; k < memWords; k++) begin
            mem[k] = fillWord(k);
            startMem[k] = mem[k];
        end
        writeCount = 0;
        pc = 0;
        npc = 1;
        steps = 0;
        while (pc != programLength && steps < maxSteps) begin
            instr = programWords[pc];
            op = instr[31:26];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            imm = {{16{instr[15]}}, instr[15:0]};
            addr = a + imm;
            dest = '0;
            value = '0;
            nextNpc = npc + 1;
            case (op)
                opSpecial: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        fnAddu: value = a + b;
                        fnSubu: value = a - b;
                        fnAnd: value = a & b;
                        fnOr: value = a | b;
                        fnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: dest = '0;
                    endcase
                end
                opAddiu: begin
                    dest = instr[20:16];
                    value = a + imm;
                end
                opOri: begin
                    dest = instr[20:16];
                    value = a | {16'b0, instr[15:0]};
                end
                opLui: begin
                    dest = instr[20:16];
                    value = {instr[15:0], 16'b0};
                end
                opLw: begin
                    dest = instr[20:16];
                    value = mem[addr[5:2]];
                end
                opSw: mem[addr[5:2]] = b;
                opBeq: begin
                    if (a == b) begin
                        nextNpc = pc + 1 + int'($signed(instr[15:0]));
                    end
                end
                opBne: begin
                    if (a != b) begin
                        nextNpc = pc + 1 + int'($signed(instr[15:0]));
                    end
                end
                opJ: nextNpc = int'(instr[25:0]);
                default: ;
            endcase
            if (dest != '0) begin
                regs[dest] = value;
                expPc[writeCount] = word_t'(pc) * 32'd4;
                expReg[writeCount] = dest;
                expValue[writeCount] = value;
                writeCount++;
            end
            pc = npc;
            npc = nextNpc;
            steps++;
        end
        for (int k = 0; k < memWords; k++) begin
            finalMem[k] = mem[k];
        end
    endtask

endmodule

`default_nettype wire

// ==== test/mipsCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;
    import cpuPkg::*;

    localparam int memWords = 16;
    localparam int writeTimeout = 20000;
    localparam int settleTimeout = 2000;
    localparam word_t loopAddr = 32'd800;

    logic clk;
    logic reset;
    word_t instAddr;
    logic instRead;
    word_t instData;
    logic instValid;
    word_t dataAddr;
    logic dataRead;
    logic dataWrite;
    word_t dataWdata;
    word_t dataRdata;
    logic dataValid;
    word_t debugPc;
    logic [3:0] debugWen;
    regAddr_t debugWnum;
    word_t debugWdata;

    word_t imem [256];
    word_t dmem [memWords];
    int instDelay;
    int dataDelay;
    int seenWrites;

    isaModel model ();

    mipsCore i_mipsCore (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instRead(instRead),
        .instData(instData),
        .instValid(instValid),
        .dataAddr(dataAddr),
        .dataRead(dataRead),
        .dataWrite(dataWrite),
        .dataWdata(dataWdata),
        .dataRdata(dataRdata),
        .dataValid(dataValid),
        .debugPc(debugPc),
        .debugWen(debugWen),
        .debugWnum(debugWnum),
        .debugWdata(debugWdata)
    );

    always #10 clk = ~clk;

    // Memories answer at the current address
    assign instData = imem[instAddr[9:2]];
    assign dataRdata = dmem[dataAddr[5:2]];

    // Valid strobes after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (reset) begin
            instValid <= 1'b0;
            instDelay <= $urandom % 4;
        end else if (instDelay == 0) begin
            instValid <= 1'b1;
            instDelay <= $urandom % 4;
        end else begin
            instValid <= 1'b0;
            instDelay <= instDelay - 1;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            dataValid <= 1'b0;
            dataDelay <= $urandom % 4;
        end else begin
            if (dataWrite && dataValid) begin
                dmem[dataAddr[5:2]] <= dataWdata;
            end
            if (dataDelay == 0) begin
                dataValid <= 1'b1;
                dataDelay <= $urandom % 4;
            end else begin
                dataValid <= 1'b0;
                dataDelay <= dataDelay - 1;
            end
        end
    end

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic checkReg(input string name, input regAddr_t expected, input regAddr_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic checkPc(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkQuietOutputs(input string name);
        checkWord({name, " debugWen"}, '0, word_t'(debugWen));
        checkWord({name, " dataRead"}, '0, word_t'(dataRead));
        checkWord({name, " dataWrite"}, '0, word_t'(dataWrite));
    endtask

    initial begin
        int seed;
        int cycles;
        int quiet;
        seed = 32'h8d4b980d;
        void'($urandom(seed));
        clk = 1'b0;
        reset = 1'b1;
        instValid = 1'b0;
        dataValid = 1'b0;
        instDelay = 0;
        dataDelay = 0;
        seenWrites = 0;

        model.buildProgram();
        model.runProgram();
        for (int k = 0; k < 256; k++) begin
            imem[k] = model.programWords[k];
        end
        for (int k = 0; k < memWords; k++) begin
            dmem[k] = model.startMem[k];
        end

        @(negedge clk);
        checkQuietOutputs("reset");
        checkWord("reset instRead", '0, word_t'(instRead));
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkQuietOutputs("reset release");
        checkWord("reset release instRead", '0, word_t'(instRead));
        @(negedge clk);
        checkQuietOutputs("after reset");
        // Fetch requests start one cycle after reset
        checkWord("after reset instRead", 32'd1, word_t'(instRead));

        // Writes in program order
        cycles = 0;
        while (seenWrites < model.writeCount) begin
            @(negedge clk);
            cycles++;
            if (cycles > writeTimeout) begin
                stopWithFailure("Timed out waiting for the next register write");
            end
            if (debugWen != 4'b0000) begin
                checkPc($sformatf("write %0d pc", seenWrites), model.expPc[seenWrites], debugPc);
                checkReg($sformatf("write %0d register", seenWrites),
                    model.expReg[seenWrites], debugWnum);
                checkWord($sformatf("write %0d value", seenWrites),
                    model.expValue[seenWrites], debugWdata);
                seenWrites++;
            end
        end

        // Drain until the final loop runs with no data traffic
        cycles = 0;
        quiet = 0;
        while (quiet < 10) begin
            @(negedge clk);
            cycles++;
            if (cycles > settleTimeout) begin
                stopWithFailure("Timed out waiting for the program to reach its final loop");
            end
            if (debugWen != 4'b0000) begin
                stopWithFailure("A register was written after the last expected write");
            end
            if (instAddr >= loopAddr && !dataRead && !dataWrite) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end

        for (int k = 0; k < memWords; k++) begin
            checkWord($sformatf("data memory word %0d", k), model.finalMem[k], dmem[k]);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsCore.f ====
rtl/cpuPkg.sv
rtl/isaPkg.sv
rtl/stageLink.sv
rtl/fetchUnit.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/writebackStage.sv
rtl/mipsCore.sv
test/isaModel.sv
test/mipsCoreTb.sv

// ==== Bender.yml ====
package:
  name: mipsCore

sources:
  - rtl/cpuPkg.sv
  - rtl/isaPkg.sv
  - rtl/stageLink.sv
  - rtl/fetchUnit.sv
  - rtl/registerFile.sv
  - rtl/decodeStage.sv
  - rtl/executeStage.sv
  - rtl/writebackStage.sv
  - rtl/mipsCore.sv
  - target: test
    files:
      - test/isaModel.sv
      - test/mipsCoreTb.sv
